//--- hw/n64_frontend_pkg.sv
// Console frontend shared definitions
package n64_frontend_pkg;

	// ==================================================
	// Widths
	// ==================================================
	localparam int IOCTL_ADDR_W = 27;
	localparam int IOCTL_DATA_W = 16;
	localparam int PIF_ADDR_W   = 10;
	localparam int AR_W         = 13;

	// Handheld cartridge image sits 8 MiB into RAM
	localparam logic [IOCTL_ADDR_W-1:0] CARTGB_BASE = 27'd8388608;

	// Loader index values, low six bits only
	localparam logic [5:0] IDX_PIFROM   = 6'd0;
	localparam logic [5:0] IDX_CART_N64 = 6'd1;
	localparam logic [5:0] IDX_CART_GB  = 6'd2;

	// ==================================================
	// Enums
	// ==================================================
	typedef enum logic [1:0] {
		DL_IDLE     = 2'd0,
		DL_PIFROM   = 2'd1,
		DL_CART_N64 = 2'd2,
		DL_CART_GB  = 2'd3
	} dl_state_e;

	// Vertical crop setting from the menu
	typedef enum logic [1:0] {
		CROP_NONE = 2'd0,
		CROP_8    = 2'd1,
		CROP_12   = 2'd2
	} crop_e;

	// ==================================================
	// Structs
	// ==================================================
	typedef struct packed {
		logic                    download;
		logic                    wr;
		logic [IOCTL_ADDR_W-1:0] addr;
		logic [IOCTL_DATA_W-1:0] data;
		logic [7:0]              index;
	} ioctl_bus_t;

	typedef struct packed {
		logic pif;
		logic n64;
		logic gb;
	} dl_mode_t;

	typedef struct packed {
		logic                  wren;
		logic [PIF_ADDR_W-1:0] addr;
		logic [31:0]           data;
	} pifrom_wr_t;

	typedef struct packed {
		logic                    wr;
		logic [IOCTL_ADDR_W-1:0] addr;
		logic [31:0]             data;
	} ram_wr_t;

	typedef struct packed {
		logic       is_pal;
		logic       fixed_blanks_off;
		crop_e      crop;
		logic [1:0] ar_mode;
	} video_cfg_t;

	// Controller adapter side
	typedef struct packed {
		logic       enable;
		logic [1:0] pad;
		logic       dout;
	} snac_link_t;

endpackage

//--- hw/download_ctrl.sv
// Download classification control
module download_ctrl (
	input  logic                                              clk_1x,
	input  logic                                              RESET,
	input  n64_frontend_pkg::ioctl_bus_t                      ioctl,
	output n64_frontend_pkg::dl_mode_t                        mode,
	output logic                                              romcopy_start,
	output logic [n64_frontend_pkg::IOCTL_ADDR_W-1:0]         romcopy_size,
	output logic                                              cart_loaded
);
	import n64_frontend_pkg::*;

	dl_state_e state;
	dl_state_e state_next;
	logic      download_d;
	logic      end_of_n64;

	// Next state follows the level and the index directly
	always_comb begin
		state_next = DL_IDLE;
		if (ioctl.download) begin
			unique case (ioctl.index[5:0])
				IDX_PIFROM:   state_next = DL_PIFROM;
				IDX_CART_N64: state_next = DL_CART_N64;
				IDX_CART_GB:  state_next = DL_CART_GB;
				default:      state_next = DL_IDLE;
			endcase
		end
	end

	// Falling edge of the download level while on the main cartridge
	assign end_of_n64 = !ioctl.download && download_d && (ioctl.index[5:0] == IDX_CART_N64);

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			state         <= DL_IDLE;
			download_d    <= 1'b0;
			romcopy_start <= 1'b0;
			cart_loaded   <= 1'b0;
		end else begin
			state         <= state_next;
			download_d    <= ioctl.download;
			romcopy_start <= end_of_n64;
			// Sticky until reset
			if (state_next == DL_CART_N64)
				cart_loaded <= 1'b1;
		end
	end

	// Size is held between copy starts
	always_ff @(posedge clk_1x) begin
		if (end_of_n64)
			romcopy_size <= ioctl.addr;
	end

	// One-hot mode decode from the registered state
	always_comb begin
		mode = '0;
		unique case (state)
			DL_PIFROM:   mode.pif = 1'b1;
			DL_CART_N64: mode.n64 = 1'b1;
			DL_CART_GB:  mode.gb  = 1'b1;
			default:     mode     = '0;
		endcase
	end

	// Packers rely on at most one flag being set
	a_mode_onehot: assert property (@(posedge clk_1x) disable iff (!RESET)
		$onehot0(mode));

endmodule

//--- hw/pifrom_packer.sv
// Boot ROM word packer
module pifrom_packer (
	input  logic                         clk_1x,
	input  logic                         RESET,
	input  n64_frontend_pkg::ioctl_bus_t ioctl,
	input  logic                         active,
	output n64_frontend_pkg::pifrom_wr_t pifrom
);
	import n64_frontend_pkg::*;

	logic                  wren_q;
	logic [PIF_ADDR_W-1:0] addr_q;
	logic [31:0]           data_q;
	logic [15:0]           half_swapped;
	logic                  strobe;

	// Boot ROM is big endian relative to the loader
	assign half_swapped = {ioctl.data[7:0], ioctl.data[15:8]};
	assign strobe       = active && ioctl.wr;

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			wren_q <= 1'b0;
		end else begin
			wren_q <= strobe && ioctl.addr[1];
		end
	end

	// First halfword also fixes the word address
	always_ff @(posedge clk_1x) begin
		if (strobe) begin
			if (!ioctl.addr[1]) begin
				data_q[31:16] <= half_swapped;
				addr_q        <= {ioctl.index[6], ioctl.addr[10:2]};
			end else begin
				data_q[15:0]  <= half_swapped;
			end
		end
	end

	assign pifrom = '{wren: wren_q, addr: addr_q, data: data_q};

	// A pair takes at least two strobes
	a_wren_single: assert property (@(posedge clk_1x) disable iff (!RESET)
		pifrom.wren |=> !pifrom.wren);

endmodule

//--- hw/cart_ram_writer.sv
// Handheld cartridge RAM writer
module cart_ram_writer #(
	parameter logic [n64_frontend_pkg::IOCTL_ADDR_W-1:0] GB_BASE = n64_frontend_pkg::CARTGB_BASE
) (
	input  logic                         clk_1x,
	input  logic                         RESET,
	input  n64_frontend_pkg::ioctl_bus_t ioctl,
	input  logic                         active,
	input  logic                         ram_ready,
	output n64_frontend_pkg::ram_wr_t    ram_wr,
	output logic                         ioctl_wait
);
	import n64_frontend_pkg::*;

	logic                    wr_q;
	logic [IOCTL_ADDR_W-1:0] addr_q;
	logic [31:0]             data_q;
	logic                    strobe;

	assign strobe = active && ioctl.wr;

	// ==================================================
	// Write pulse and loader stall
	// ==================================================
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			wr_q       <= 1'b0;
			ioctl_wait <= 1'b0;
		end else if (!active) begin
			wr_q       <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			wr_q <= strobe && ioctl.addr[1];
			if (strobe && ioctl.addr[1])
				ioctl_wait <= 1'b1;
			// Ready ends the stall one cycle later
			if (ram_ready)
				ioctl_wait <= 1'b0;
		end
	end

	// ==================================================
	// Word assembly, little endian halfwords
	// ==================================================
	always_ff @(posedge clk_1x) begin
		if (strobe) begin
			if (!ioctl.addr[1]) begin
				data_q[15:0] <= ioctl.data;
				addr_q       <= ioctl.addr + GB_BASE;
			end else begin
				data_q[31:16] <= ioctl.data;
			end
		end
	end

	assign ram_wr = '{wr: wr_q, addr: addr_q, data: data_q};

	// Loader must honour the wait level
	a_no_wr_in_wait: assert property (@(posedge clk_1x) disable iff (!RESET)
		ioctl_wait |-> !ioctl.wr);

endmodule

//--- hw/aspect_ratio_sel.sv
// Video aspect ratio select
module aspect_ratio_sel (
	input  logic                                clk_1x,
	input  logic                                RESET,
	input  n64_frontend_pkg::video_cfg_t        cfg,
	output logic [n64_frontend_pkg::AR_W-1:0]   video_arx,
	output logic [n64_frontend_pkg::AR_W-1:0]   video_ary
);
	import n64_frontend_pkg::*;

	logic [AR_W-1:0] core_x;
	logic [AR_W-1:0] core_y;

	// ==================================================
	// Core ratio from region and crop
	// ==================================================
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			core_x <= 13'd4;
			core_y <= 13'd3;
		end else if (cfg.fixed_blanks_off) begin
			core_x <= 13'd4;
			core_y <= 13'd3;
		end else if (cfg.is_pal) begin
			case (cfg.crop)
				CROP_NONE: begin
					core_x <= 13'd512;
					core_y <= 13'd387;
				end
				CROP_8: begin
					core_x <= 13'd1024;
					core_y <= 13'd731;
				end
				CROP_12: begin
					core_x <= 13'd2048;
					core_y <= 13'd1419;
				end
				default: ;  // unused crop code holds the last ratio
			endcase
		end else begin
			case (cfg.crop)
				CROP_NONE: begin
					core_x <= 13'd512;
					core_y <= 13'd381;
				end
				CROP_8: begin
					core_x <= 13'd1280;
					core_y <= 13'd889;
				end
				CROP_12: begin
					core_x <= 13'd2560;
					core_y <= 13'd1714;
				end
				default: ;
			endcase
		end
	end

	// Nonzero mode selects a scaler preset instead
	assign video_arx = (cfg.ar_mode == 2'd0) ? core_x : AR_W'(cfg.ar_mode - 2'd1);
	assign video_ary = (cfg.ar_mode == 2'd0) ? core_y : '0;

endmodule

//--- hw/snac_port_mux.sv
// Controller adapter user port routing
module snac_port_mux (
	input  logic                         clk_1x,
	input  logic                         RESET,
	input  n64_frontend_pkg::snac_link_t snac,
	input  logic [6:0]                   user_in,
	output logic [6:0]                   user_out,
	output logic                         snac_data_in
);

	logic [2:0] pad_pin;

	// Pads 1 and 2 on D-/D+, pads 3 and 4 on RX-/RX+
	always_comb begin
		case (snac.pad)
			2'd0:    pad_pin = 3'd1;
			2'd1:    pad_pin = 3'd0;
			2'd2:    pad_pin = 3'd5;
			default: pad_pin = 3'd4;
		endcase
	end

	// Open drain port where a 1 releases the pin
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			user_out <= '1;
		end else if (snac.enable) begin
			user_out[pad_pin] <= snac.dout;
			user_out[2]       <= 1'b1;
			user_out[3]       <= 1'b1;
			user_out[6]       <= 1'b1;
		end else begin
			user_out <= '1;
		end
	end

	// Sample the selected pin back toward the core
	always_ff @(posedge clk_1x) begin
		if (snac.enable)
			snac_data_in <= user_in[pad_pin];
	end

endmodule

//--- hw/n64_frontend.sv
// Console download and panel frontend
module n64_frontend #(
	parameter logic [n64_frontend_pkg::IOCTL_ADDR_W-1:0] GB_BASE = n64_frontend_pkg::CARTGB_BASE
) (
	input  logic                                      clk_1x,
	input  logic                                      RESET,

	// Loader and RAM
	input  n64_frontend_pkg::ioctl_bus_t              ioctl,
	input  logic                                      ram_ready,
	output n64_frontend_pkg::pifrom_wr_t              pifrom,
	output n64_frontend_pkg::ram_wr_t                 ram_wr,
	output logic                                      ioctl_wait,
	output logic                                      romcopy_start,
	output logic [n64_frontend_pkg::IOCTL_ADDR_W-1:0] romcopy_size,
	output logic                                      cart_loaded,

	// Display and user port
	input  n64_frontend_pkg::video_cfg_t              cfg,
	input  n64_frontend_pkg::snac_link_t              snac,
	input  logic [6:0]                                user_in,
	output logic [n64_frontend_pkg::AR_W-1:0]         video_arx,
	output logic [n64_frontend_pkg::AR_W-1:0]         video_ary,
	output logic [6:0]                                user_out,
	output logic                                      snac_data_in
);
	import n64_frontend_pkg::*;

	dl_mode_t mode;

	// ==================================================
	// Download path
	// ==================================================
	download_ctrl i_download_ctrl (
		.clk_1x        (clk_1x),
		.RESET         (RESET),
		.ioctl         (ioctl),
		.mode          (mode),
		.romcopy_start (romcopy_start),
		.romcopy_size  (romcopy_size),
		.cart_loaded   (cart_loaded)
	);

	pifrom_packer i_pifrom_packer (
		.clk_1x (clk_1x),
		.RESET  (RESET),
		.ioctl  (ioctl),
		.active (mode.pif),
		.pifrom (pifrom)
	);

	cart_ram_writer #(
		.GB_BASE (GB_BASE)
	) i_cart_ram_writer (
		.clk_1x     (clk_1x),
		.RESET      (RESET),
		.ioctl      (ioctl),
		.active     (mode.gb),
		.ram_ready  (ram_ready),
		.ram_wr     (ram_wr),
		.ioctl_wait (ioctl_wait)
	);

	// ==================================================
	// Panel glue
	// ==================================================
	aspect_ratio_sel i_aspect_ratio_sel (
		.clk_1x    (clk_1x),
		.RESET     (RESET),
		.cfg       (cfg),
		.video_arx (video_arx),
		.video_ary (video_ary)
	);

	snac_port_mux i_snac_port_mux (
		.clk_1x       (clk_1x),
		.RESET        (RESET),
		.snac         (snac),
		.user_in      (user_in),
		.user_out     (user_out),
		.snac_data_in (snac_data_in)
	);

endmodule

//--- tests/tb_n64_frontend.sv
// Console frontend testbench
module tb_n64_frontend;
	timeunit 1ns;
	timeprecision 1ps;
	import n64_frontend_pkg::*;

	localparam int TIMEOUT = 40;

	logic                    clk_1x;
	logic                    RESET;
	ioctl_bus_t              ioctl;
	logic                    ram_ready;
	video_cfg_t              cfg;
	snac_link_t              snac;
	logic [6:0]              user_in;
	pifrom_wr_t              pifrom;
	ram_wr_t                 ram_wr;
	logic                    ioctl_wait;
	logic                    romcopy_start;
	logic [IOCTL_ADDR_W-1:0] romcopy_size;
	logic                    cart_loaded;
	logic [AR_W-1:0]         video_arx;
	logic [AR_W-1:0]         video_ary;
	logic [6:0]              user_out;
	logic                    snac_data_in;

	integer seed = 32'h61c7;
	string  test_name = "reset";

	// Expected values set by the stimulus ahead of each response
	logic [PIF_ADDR_W-1:0]   exp_pif_addr;
	logic [31:0]             exp_pif_data;
	logic [IOCTL_ADDR_W-1:0] exp_ram_addr;
	logic [31:0]             exp_ram_data;
	logic [IOCTL_ADDR_W-1:0] exp_copy_size;
	logic [AR_W-1:0]         exp_arx;
	logic [AR_W-1:0]         exp_ary;
	logic [2:0]              exp_pin;
	int pif_pairs = 0;
	int gb_pairs = 0;
	int pif_pulses = 0;
	int ram_pulses = 0;
	int copy_pulses = 0;

	always #10 clk_1x = ~clk_1x;

	n64_frontend i_n64_frontend (
		.clk_1x        (clk_1x),
		.RESET         (RESET),
		.ioctl         (ioctl),
		.ram_ready     (ram_ready),
		.pifrom        (pifrom),
		.ram_wr        (ram_wr),
		.ioctl_wait    (ioctl_wait),
		.romcopy_start (romcopy_start),
		.romcopy_size  (romcopy_size),
		.cart_loaded   (cart_loaded),
		.cfg           (cfg),
		.snac          (snac),
		.user_in       (user_in),
		.video_arx     (video_arx),
		.video_ary     (video_ary),
		.user_out      (user_out),
		.snac_data_in  (snac_data_in)
	);

	// ==================================================
	// Error reporting
	// ==================================================
	task automatic report_failure();
		$display("Test failed");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic fail_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("ERR %s %s expected %0h actual %0h", test_name, name, expected, actual);
		report_failure();
	endtask

	task automatic fail_plain(input string what);
		$display("%s during %s", what, test_name);
		report_failure();
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual == expected) else fail_value(name, expected, actual);
	endtask

	// ==================================================
	// Reference rules
	// ==================================================
	function automatic logic [2*AR_W-1:0] expected_aspect(input video_cfg_t c);
		logic [AR_W-1:0] x;
		logic [AR_W-1:0] y;
		x = 13'd4;
		y = 13'd3;
		if (!c.fixed_blanks_off && c.is_pal) begin
			case (c.crop)
				CROP_NONE: {x, y} = {13'd512, 13'd387};
				CROP_8:    {x, y} = {13'd1024, 13'd731};
				default:   {x, y} = {13'd2048, 13'd1419};
			endcase
		end else if (!c.fixed_blanks_off) begin
			case (c.crop)
				CROP_NONE: {x, y} = {13'd512, 13'd381};
				CROP_8:    {x, y} = {13'd1280, 13'd889};
				default:   {x, y} = {13'd2560, 13'd1714};
			endcase
		end
		// Scaler presets replace the core ratio
		if (c.ar_mode != 2'd0) begin
			x = AR_W'(c.ar_mode) - 13'd1;
			y = 13'd0;
		end
		return {x, y};
	endfunction

	function automatic logic [2:0] pin_for_pad(input logic [1:0] pad);
		case (pad)
			2'd0:    return 3'd1;
			2'd1:    return 3'd0;
			2'd2:    return 3'd5;
			default: return 3'd4;
		endcase
	endfunction

	// ==================================================
	// Response checks
	// ==================================================
	a_pif_data: assert property (@(posedge clk_1x) disable iff (!RESET)
		pifrom.wren |-> pifrom.data == exp_pif_data)
		else fail_value("pifrom.data", exp_pif_data, $sampled(pifrom.data));
	a_pif_addr: assert property (@(posedge clk_1x) disable iff (!RESET)
		pifrom.wren |-> pifrom.addr == exp_pif_addr)
		else fail_value("pifrom.addr", 32'(exp_pif_addr), 32'($sampled(pifrom.addr)));
	a_ram_data: assert property (@(posedge clk_1x) disable iff (!RESET)
		ram_wr.wr |-> ram_wr.data == exp_ram_data)
		else fail_value("ram_wr.data", exp_ram_data, $sampled(ram_wr.data));
	a_ram_addr: assert property (@(posedge clk_1x) disable iff (!RESET)
		ram_wr.wr |-> ram_wr.addr == exp_ram_addr)
		else fail_value("ram_wr.addr", 32'(exp_ram_addr), 32'($sampled(ram_wr.addr)));

	// Wait covers the write until the cycle after ready
	a_wait_with_wr: assert property (@(posedge clk_1x) disable iff (!RESET)
		ram_wr.wr |-> ioctl_wait) else fail_plain("ioctl_wait low during a RAM write");
	a_wait_rise: assert property (@(posedge clk_1x) disable iff (!RESET)
		$rose(ioctl_wait) |-> ram_wr.wr) else fail_plain("ioctl_wait rose without a write");
	a_wait_hold: assert property (@(posedge clk_1x) disable iff (!RESET)
		ioctl_wait && !ram_ready |=> ioctl_wait)
		else fail_plain("ioctl_wait fell before ram_ready");
	a_wait_release: assert property (@(posedge clk_1x) disable iff (!RESET)
		ioctl_wait && ram_ready |=> !ioctl_wait)
		else fail_plain("ioctl_wait stayed high after ram_ready");

	a_loaded_rise: assert property (@(posedge clk_1x) disable iff (!RESET)
		ioctl.download && ioctl.index[5:0] == IDX_CART_N64 |=> cart_loaded)
		else fail_value("cart_loaded", 32'd1, 32'($sampled(cart_loaded)));
	a_loaded_sticky: assert property (@(posedge clk_1x) disable iff (!RESET)
		cart_loaded |=> cart_loaded) else fail_plain("cart_loaded cleared without reset");
	a_copy_start: assert property (@(posedge clk_1x) disable iff (!RESET)
		$fell(ioctl.download) && ioctl.index[5:0] == IDX_CART_N64 |=> romcopy_start)
		else fail_value("romcopy_start", 32'd1, 32'($sampled(romcopy_start)));
	a_copy_size: assert property (@(posedge clk_1x) disable iff (!RESET)
		romcopy_start |-> romcopy_size == exp_copy_size)
		else fail_value("romcopy_size", 32'(exp_copy_size), 32'($sampled(romcopy_size)));
	a_copy_single: assert property (@(posedge clk_1x) disable iff (!RESET)
		romcopy_start |=> !romcopy_start) else fail_plain("romcopy_start lasted two cycles");

	a_arx: assert property (@(posedge clk_1x) disable iff (!RESET)
		$stable(cfg) |-> video_arx == exp_arx)
		else fail_value("video_arx", 32'(exp_arx), 32'($sampled(video_arx)));
	a_ary: assert property (@(posedge clk_1x) disable iff (!RESET)
		$stable(cfg) |-> video_ary == exp_ary)
		else fail_value("video_ary", 32'(exp_ary), 32'($sampled(video_ary)));

	a_snac_out: assert property (@(posedge clk_1x) disable iff (!RESET)
		snac.enable && $stable(snac) |-> user_out[exp_pin] == snac.dout)
		else fail_value("user_out pad pin", 32'(snac.dout), 32'($sampled(user_out[exp_pin])));
	a_snac_spare: assert property (@(posedge clk_1x) disable iff (!RESET)
		snac.enable && $stable(snac) |-> {user_out[6], user_out[3], user_out[2]} == 3'b111)
		else fail_value("user_out spare pins", 32'h7, 32'($sampled(user_out)));
	a_snac_in: assert property (@(posedge clk_1x) disable iff (!RESET)
		snac.enable && $stable(snac) && $stable(user_in) |-> snac_data_in == user_in[exp_pin])
		else fail_value("snac_data_in", 32'(user_in[exp_pin]), 32'($sampled(snac_data_in)));
	a_snac_off: assert property (@(posedge clk_1x) disable iff (!RESET)
		!snac.enable && $stable(snac) |-> user_out == 7'h7f)
		else fail_value("user_out", 32'h7f, 32'($sampled(user_out)));

	always @(posedge clk_1x) begin
		if (RESET) begin
			if (pifrom.wren)
				pif_pulses++;
			if (ram_wr.wr)
				ram_pulses++;
			if (romcopy_start)
				copy_pulses++;
		end
	end

	// RAM model raising ready after 1 to 6 cycles
	initial begin
		int ready_delay;
		ram_ready = 1'b0;
		forever begin
			@(negedge clk_1x);
			if (ram_wr.wr) begin
				ready_delay = 1 + int'({$random(seed)} % 6);
				repeat (ready_delay) @(negedge clk_1x);
				ram_ready = 1'b1;
				@(negedge clk_1x);
				ram_ready = 1'b0;
			end
		end
	end

	// ==================================================
	// Stimulus tasks
	// ==================================================
	task automatic write_halfword(input logic [IOCTL_ADDR_W-1:0] addr, input logic [15:0] data);
		ioctl.wr   = 1'b1;
		ioctl.addr = addr;
		ioctl.data = data;
		@(negedge clk_1x);
		ioctl.wr = 1'b0;
	endtask

	task automatic begin_download(input logic [7:0] index);
		ioctl.download = 1'b1;
		ioctl.index    = index;
		@(negedge clk_1x);
	endtask

	task automatic end_download();
		ioctl.download = 1'b0;
		repeat (2) @(negedge clk_1x);
	endtask

	task automatic wait_pif_wren();
		int cycles;
		cycles = 0;
		while (!pifrom.wren) begin
			if (cycles == TIMEOUT)
				fail_plain("Timeout waiting for a boot ROM write");
			@(negedge clk_1x);
			cycles++;
		end
	endtask

	task automatic wait_ioctl_wait_low();
		int cycles;
		cycles = 0;
		while (ioctl_wait) begin
			if (cycles == TIMEOUT)
				fail_plain("Timeout waiting for ioctl_wait to fall");
			@(negedge clk_1x);
			cycles++;
		end
	endtask

	task automatic wait_romcopy_start();
		int cycles;
		cycles = 0;
		while (!romcopy_start) begin
			if (cycles == TIMEOUT)
				fail_plain("Timeout waiting for romcopy_start");
			@(negedge clk_1x);
			cycles++;
		end
	endtask

	task automatic send_pif_pair(input logic [7:0] index);
		logic [8:0]              word;
		logic [15:0]             h0;
		logic [15:0]             h1;
		logic [IOCTL_ADDR_W-1:0] base;
		word = 9'($random(seed));
		h0   = 16'($random(seed));
		h1   = 16'($random(seed));
		base = {16'($random(seed)), word, 2'b00};
		exp_pif_data = {h0[7:0], h0[15:8], h1[7:0], h1[15:8]};
		exp_pif_addr = {index[6], word};
		pif_pairs++;
		write_halfword(base, h0);
		write_halfword(base | IOCTL_ADDR_W'(2), h1);
		wait_pif_wren();
		@(negedge clk_1x);
		check_value("pifrom.wren pulses", 32'(pif_pairs), 32'(pif_pulses));
	endtask

	task automatic send_gb_pair();
		logic [15:0]             h0;
		logic [15:0]             h1;
		logic [IOCTL_ADDR_W-1:0] addr;
		addr = {25'($random(seed)), 2'b00};
		h0   = 16'($random(seed));
		h1   = 16'($random(seed));
		exp_ram_data = {h1, h0};
		exp_ram_addr = addr + CARTGB_BASE;
		gb_pairs++;
		write_halfword(addr, h0);
		write_halfword(addr | IOCTL_ADDR_W'(2), h1);
		wait_ioctl_wait_low();
		@(negedge clk_1x);
		check_value("ram_wr.wr pulses", 32'(gb_pairs), 32'(ram_pulses));
	endtask

	task automatic apply_video_cfg(input video_cfg_t c);
		cfg = c;
		{exp_arx, exp_ary} = expected_aspect(c);
		repeat (2) @(negedge clk_1x);
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		logic [IOCTL_ADDR_W-1:0] addr;
		clk_1x  = 1'b0;
		RESET   = 1'b0;
		ioctl   = '0;
		cfg     = '{is_pal: 1'b0, fixed_blanks_off: 1'b1, crop: CROP_NONE, ar_mode: 2'd0};
		snac    = '0;
		user_in = '1;
		exp_arx = 13'd4;
		exp_ary = 13'd3;
		exp_pin = 3'd1;
		repeat (4) @(negedge clk_1x);
		RESET = 1'b1;

		check_value("pifrom.wren", 32'd0, 32'(pifrom.wren));
		check_value("ram_wr.wr", 32'd0, 32'(ram_wr.wr));
		check_value("ioctl_wait", 32'd0, 32'(ioctl_wait));
		check_value("romcopy_start", 32'd0, 32'(romcopy_start));
		check_value("cart_loaded", 32'd0, 32'(cart_loaded));
		check_value("user_out", 32'h7f, 32'(user_out));
		check_value("video_arx", 32'd4, 32'(video_arx));
		check_value("video_ary", 32'd3, 32'(video_ary));

		test_name = "pifrom";
		begin_download(8'd0);
		repeat (4) send_pif_pair(8'd0);
		end_download();
		begin_download(8'd64);
		repeat (4) send_pif_pair(8'd64);
		end_download();

		test_name = "cart_gb";
		begin_download(8'd2);
		repeat (6) send_gb_pair();
		end_download();

		test_name = "cart_n64";
		check_value("cart_loaded before download", 32'd0, 32'(cart_loaded));
		begin_download(8'd1);
		addr = {20'($random(seed)), 7'd0};
		for (int i = 0; i < 4; i++) begin
			write_halfword(addr, 16'($random(seed)));
			exp_copy_size = addr;
			addr = addr + IOCTL_ADDR_W'(2);
		end
		ioctl.download = 1'b0;
		@(negedge clk_1x);
		wait_romcopy_start();
		@(negedge clk_1x);
		check_value("romcopy_start pulses", 32'd1, 32'(copy_pulses));

		test_name = "aspect";
		for (int fb = 0; fb < 2; fb++)
			for (int p = 0; p < 2; p++)
				for (int c = 0; c < 3; c++)
					for (int m = 0; m < 4; m++)
						apply_video_cfg('{is_pal: 1'(p), fixed_blanks_off: 1'(fb),
							crop: crop_e'(c), ar_mode: 2'(m)});

		test_name = "snac_port";
		for (int p = 0; p < 4; p++) begin
			for (int b = 0; b < 2; b++) begin
				snac    = '{enable: 1'b1, pad: 2'(p), dout: 1'(b)};
				exp_pin = pin_for_pad(2'(p));
				user_in = 7'($random(seed));
				repeat (3) @(negedge clk_1x);
			end
		end
		snac.enable = 1'b0;
		repeat (3) @(negedge clk_1x);

		test_name = "totals";
		check_value("pifrom.wren total", 32'(pif_pairs), 32'(pif_pulses));
		check_value("ram_wr.wr total", 32'(gb_pairs), 32'(ram_pulses));
		check_value("romcopy_start total", 32'd1, 32'(copy_pulses));
		check_value("cart_loaded", 32'd1, 32'(cart_loaded));
		$display("Test passed");
		$finish;
	end

endmodule

//--- n64_frontend.f
hw/n64_frontend_pkg.sv
hw/download_ctrl.sv
hw/pifrom_packer.sv
hw/cart_ram_writer.sv
hw/aspect_ratio_sel.sv
hw/snac_port_mux.sv
hw/n64_frontend.sv
tests/tb_n64_frontend.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
LINT     = --lint-only --timing
TOP      = tb_n64_frontend
RTL_TOP  = n64_frontend
FILELIST = n64_frontend.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/$(TOP)

lint:
	$(SIM) $(LINT) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
